//--- src/beat_params.svh
`ifndef BEAT_PARAMS_SVH
`define BEAT_PARAMS_SVH

// audio sample and filter coefficient widths
`define SAMPLE_WIDTH 8
`define COEFF_WIDTH 16

// serial fir, taps must be a power of two for the ring buffer
`define FIR_TAPS 32
`define FIR_TAP_WIDTH 5
`define FIR_ACC_WIDTH 24
// output is accumulator bits 23..16
`define FIR_OUT_SHIFT 16

// energy novelty, window of 2**log2 samples
`define ENF_WINDOW_LOG2 4
`define ENF_WIDTH 32
`define ENF_DIFF_WIDTH 42
`define ENF_SHIFT 4

// peak picking
`define PEAK_HOLDOFF 24
`define PEAK_HOLDOFF_WIDTH 5
`define PEAK_MAX_SHIFT 3

`endif

//--- src/beat_pkg.sv
`include "beat_params.svh"

package beat_pkg;

  ////////////////////
  // stream types
  ////////////////////

  // one audio sample with its strobe
  typedef struct packed {
    logic                             strobe;
    logic signed [`SAMPLE_WIDTH-1:0]  value;
  } sample_t;

  ////////////////////
  // debug word
  ////////////////////

  // novelty with the beat flag folded into bit 0
  typedef struct packed {
    logic [`ENF_WIDTH-2:0]  energy_hi;
    logic                   beat;
  } debug_flagged_t;

  // same 32 bits, read as a plain word or as energy plus flag
  typedef union packed {
    logic [`ENF_WIDTH-1:0]  raw;
    debug_flagged_t         flagged;
  } debug_word_u;

endpackage

//--- src/fir_coeff_rom.sv
`timescale 1ns/1ps
`include "beat_params.svh"

// symmetric low-pass, coefficients scaled by 2**16, dc gain of one
module fir_coeff_rom (
  input  logic [`FIR_TAP_WIDTH:0]         index,
  output logic signed [`COEFF_WIDTH-1:0]  coeff
);

  always_comb begin
    case (index)
      0: coeff = -16'sd40;
      1: coeff = -16'sd60;
      2: coeff = -16'sd70;
      3: coeff = -16'sd50;
      4: coeff = 16'sd0;
      5: coeff = 16'sd145;
      6: coeff = 16'sd410;
      7: coeff = 16'sd820;
      8: coeff = 16'sd1386;
      9: coeff = 16'sd2098;
      10: coeff = 16'sd2918;
      11: coeff = 16'sd3773;
      12: coeff = 16'sd4581;
      13: coeff = 16'sd5256;
      14: coeff = 16'sd5714;
      15: coeff = 16'sd5909;
      // second half mirrors the first
      16: coeff = 16'sd5909;
      17: coeff = 16'sd5714;
      18: coeff = 16'sd5256;
      19: coeff = 16'sd4581;
      20: coeff = 16'sd3773;
      21: coeff = 16'sd2918;
      22: coeff = 16'sd2098;
      23: coeff = 16'sd1386;
      24: coeff = 16'sd820;
      25: coeff = 16'sd410;
      26: coeff = 16'sd145;
      27: coeff = 16'sd0;
      28: coeff = -16'sd50;
      29: coeff = -16'sd70;
      30: coeff = -16'sd60;
      31: coeff = -16'sd40;
      // past the last tap, so the sum stays put
      default: coeff = '0;
    endcase
  end

endmodule

//--- src/fir_filter.sv
`timescale 1ns/1ps
`include "beat_params.svh"

module fir_filter (
  input  logic                               clock,
  input  logic                               reset,
  input  beat_pkg::sample_t                  sample,
  output logic signed [`FIR_ACC_WIDTH-1:0]   filter_out
);

  localparam logic [`FIR_TAP_WIDTH:0] tap_count = `FIR_TAPS;

  logic signed [`SAMPLE_WIDTH-1:0]                ring [tap_count];
  logic [`FIR_TAP_WIDTH-1:0]                      offset;
  // extra msb lets the index run one past the last tap
  logic [`FIR_TAP_WIDTH:0]                        index;
  logic [`FIR_TAP_WIDTH-1:0]                      tap_addr;
  logic signed [`COEFF_WIDTH-1:0]                 coeff;
  logic signed [`COEFF_WIDTH+`SAMPLE_WIDTH-1:0]   product;
  logic signed [`FIR_ACC_WIDTH-1:0]               acc;
  logic [`FIR_TAP_WIDTH-2:0]                      clear_count;
  logic                                           clearing;

  fir_coeff_rom coeff_rom (
    .index (index),
    .coeff (coeff)
  );

  // newest sample sits at offset with older ones further back
  assign tap_addr = offset - index[`FIR_TAP_WIDTH-1:0];
  assign product  = coeff * ring[tap_addr];

  ////////////////////
  // ring buffer
  ////////////////////

  // after reset two entries are zeroed per clock in opposite halves
  always_ff @(posedge clock) begin
    if (clearing) begin
      ring[{1'b0, clear_count}] <= '0;
      ring[{1'b1, clear_count}] <= '0;
    end
    if (sample.strobe) begin
      ring[offset + 1'b1] <= sample.value;
    end
  end

  ////////////////////
  // mac sequencer
  ////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      offset      <= '0;
      index       <= tap_count;
      acc         <= '0;
      filter_out  <= '0;
      clear_count <= '0;
      clearing    <= 1'b1;
    end else begin
      if (clearing) begin
        clear_count <= clear_count + 1'b1;
        if (&clear_count) begin
          clearing <= 1'b0;
        end
      end
      if (sample.strobe) begin
        // offset moves onto the slot just written
        offset <= offset + 1'b1;
        index  <= '0;
        acc    <= '0;
      end else if (index < tap_count) begin
        acc   <= acc + product;
        index <= index + 1'b1;
      end else begin
        filter_out <= acc;
      end
    end
  end

endmodule

//--- src/energy_novelty.sv
`timescale 1ns/1ps
`include "beat_params.svh"

module energy_novelty (
  input  logic                      clock,
  input  logic                      reset,
  input  beat_pkg::sample_t         sample,
  output logic [`ENF_WIDTH-1:0]     novelty
);

  localparam int unsigned depth = 2 ** `ENF_WINDOW_LOG2;

  logic signed [2*`SAMPLE_WIDTH-1:0]  square;
  logic signed [2*`SAMPLE_WIDTH-1:0]  square_mem [depth];
  logic signed [2*`SAMPLE_WIDTH-1:0]  delayed_mem [depth];
  logic signed [`ENF_WIDTH-1:0]       diff_mem [depth];
  logic signed [`ENF_WIDTH-1:0]       cur_energy;
  logic signed [`ENF_WIDTH-1:0]       prev_energy;
  logic signed [`ENF_WIDTH-1:0]       energy_diff;
  logic signed [`ENF_DIFF_WIDTH-1:0]  diff_acc;
  logic signed [`ENF_DIFF_WIDTH-1:0]  shifted;
  logic [`ENF_WINDOW_LOG2-1:0]        index;
  logic [`ENF_WINDOW_LOG2-1:0]        clear_count;
  logic                               clearing;

  assign square      = $signed(sample.value) * $signed(sample.value);
  assign energy_diff = cur_energy - prev_energy;

  ////////////////////
  // window memories
  ////////////////////

  // square_mem holds the current window, delayed_mem the one before it
  always_ff @(posedge clock) begin
    if (clearing) begin
      square_mem[clear_count]  <= '0;
      delayed_mem[clear_count] <= '0;
      diff_mem[clear_count]    <= '0;
    end
    if (sample.strobe) begin
      square_mem[index]  <= square;
      delayed_mem[index] <= square_mem[index];
      diff_mem[index]    <= energy_diff;
    end
  end

  ////////////////////
  // running sums
  ////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      cur_energy  <= '0;
      prev_energy <= '0;
      diff_acc    <= '0;
      index       <= '0;
      clear_count <= '0;
      clearing    <= 1'b1;
    end else begin
      if (clearing) begin
        clear_count <= clear_count + 1'b1;
        if (&clear_count) begin
          clearing <= 1'b0;
        end
      end
      if (sample.strobe) begin
        // the sample leaving the current window enters the previous one
        prev_energy <= prev_energy - delayed_mem[index] + square_mem[index];
        cur_energy  <= cur_energy - square_mem[index] + square;
        diff_acc    <= diff_acc + energy_diff - diff_mem[index];
        index       <= index + 1'b1;
      end
    end
  end

  // scale down, falling energy reads as zero
  assign shifted = diff_acc >>> `ENF_SHIFT;
  assign novelty = diff_acc[`ENF_DIFF_WIDTH-1] ? '0 : shifted[`ENF_WIDTH-1:0];

endmodule

//--- src/peak_picker.sv
`timescale 1ns/1ps
`include "beat_params.svh"

module peak_picker (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    ready,
  input  logic [`ENF_WIDTH-1:0]   novelty,
  output logic                    beat
);

  localparam logic [`PEAK_HOLDOFF_WIDTH-1:0] holdoff_reload = `PEAK_HOLDOFF;

  logic [`ENF_WIDTH-1:0]            newer;
  logic [`ENF_WIDTH-1:0]            older;
  logic [`ENF_WIDTH-1:0]            max_val;
  logic [`PEAK_HOLDOFF_WIDTH-1:0]   holdoff;
  logic                             is_peak;

  // newer is the candidate, older and the incoming value its neighbours
  assign is_peak = (older < newer) &&
                   (newer >= novelty) &&
                   (newer > (max_val >> `PEAK_MAX_SHIFT)) &&
                   (holdoff == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      beat    <= 1'b0;
      newer   <= '0;
      older   <= '0;
      max_val <= '0;
      holdoff <= '0;
    end else if (ready) begin
      beat  <= is_peak;
      older <= newer;
      newer <= novelty;
      if (novelty > max_val) begin
        max_val <= novelty;
      end
      // block further peaks for a while
      if (is_peak) begin
        holdoff <= holdoff_reload;
      end else if (holdoff != '0) begin
        holdoff <= holdoff - 1'b1;
      end
    end
  end

endmodule

//--- src/audio_processor.sv
`timescale 1ns/1ps
`include "beat_params.svh"

module audio_processor (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            ready,
  input  logic signed [`SAMPLE_WIDTH-1:0] x,
  output logic [`SAMPLE_WIDTH-1:0]        y,
  output logic                            beat,
  output logic [`ENF_WIDTH-1:0]           d
);

  import beat_pkg::*;

  sample_t                            raw_sample;
  sample_t                            filtered_sample;
  logic signed [`FIR_ACC_WIDTH-1:0]   filter_out;
  logic [`ENF_WIDTH-1:0]              novelty;
  debug_word_u                        debug_word;

  assign raw_sample = '{strobe: ready, value: x};

  fir_filter filter (
    .clock      (clock),
    .reset      (reset),
    .sample     (raw_sample),
    .filter_out (filter_out)
  );

  // the top byte of the accumulator is the 8-bit result
  assign y = filter_out[`FIR_ACC_WIDTH-1:`FIR_OUT_SHIFT];
  assign filtered_sample = '{strobe: ready, value: filter_out[`FIR_ACC_WIDTH-1:`FIR_OUT_SHIFT]};

  energy_novelty novelty_stage (
    .clock   (clock),
    .reset   (reset),
    .sample  (filtered_sample),
    .novelty (novelty)
  );

  peak_picker peaks (
    .clock   (clock),
    .reset   (reset),
    .ready   (ready),
    .novelty (novelty),
    .beat    (beat)
  );

  // bit 0 of the novelty gives way to the beat flag
  always_comb begin
    debug_word.flagged.energy_hi = novelty[`ENF_WIDTH-1:1];
    debug_word.flagged.beat      = beat;
  end

  assign d = debug_word.raw;

endmodule

//--- verif/audio_processor_tb.sv
`timescale 1ns/1ps
`include "beat_params.svh"

module audio_processor_tb;

  import beat_pkg::*;

  localparam int clear_wait    = 1 << `ENF_WINDOW_LOG2;
  localparam int sample_period = 40;
  localparam int min_lines     = `FIR_TAPS;

  logic                             clock;
  logic                             reset;
  logic                             ready;
  logic signed [`SAMPLE_WIDTH-1:0]  x;
  logic [`SAMPLE_WIDTH-1:0]         y;
  logic                             beat;
  logic [`ENF_WIDTH-1:0]            d;

  debug_word_u  debug_view;

  // one entry per trace line
  int trace_x[$];
  int trace_y[$];
  int trace_beat[$];
  int trace_d[$];

  int error_count;
  bit trace_loaded;

  audio_processor DUT (
    .clock (clock),
    .reset (reset),
    .ready (ready),
    .x     (x),
    .y     (y),
    .beat  (beat),
    .d     (d)
  );

  always #50 clock = ~clock;

  assign debug_view.raw = d;

  ////////////////////
  // helpers
  ////////////////////

  task automatic check_value(input string name, input logic signed [31:0] expected,
                             input logic signed [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  // blank lines and lines starting with # are skipped
  task automatic read_trace(output bit ok);
    int    fd;
    int    code;
    int    fields;
    int    xv;
    int    yv;
    int    bv;
    int    dv;
    string line;
    ok = 1'b0;
    fd = $fopen("verif/audio_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file verif/audio_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line[0] != "#") begin
          fields = $sscanf(line, "%d %d %d %d", xv, yv, bv, dv);
          if (fields == 4) begin
            trace_x.push_back(xv);
            trace_y.push_back(yv);
            trace_beat.push_back(bv);
            trace_d.push_back(dv);
          end else begin
            error_count++;
            $display("trace line could not be parsed: %s", line);
          end
        end
      end
      $fclose(fd);
      if (trace_x.size() < min_lines) begin
        $display("trace file is too short, %0d samples read", trace_x.size());
      end else begin
        ok = 1'b1;
      end
    end
  endtask

  // outputs for one sample as seen on the falling edge before the next ready
  task automatic check_line(input int k);
    check_value("y", trace_y[k], $signed(y));
    check_value("beat", trace_beat[k], beat);
    check_value("d", trace_d[k], d);
    // bit 0 of the debug word carries the beat flag
    check_value("d[0]", trace_beat[k], debug_view.flagged.beat);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    bit ok;
    clock        = 1'b0;
    reset        = 1'b1;
    ready        = 1'b0;
    x            = '0;
    error_count  = 0;
    trace_loaded = 1'b0;

    read_trace(ok);

    if (!ok) begin
      $display("Checks failed");
      $finish;
    end else begin
      trace_loaded = 1'b1;

      repeat (2) @(negedge clock);
      reset = 1'b0;

      // the sample memories clear themselves after reset
      repeat (clear_wait) @(negedge clock);

      // idle outputs after reset
      check_value("y", 0, $signed(y));
      check_value("beat", 0, beat);
      check_value("d", 0, d);

      for (int k = 0; k < trace_x.size(); k++) begin
        @(negedge clock);
        x     = trace_x[k][`SAMPLE_WIDTH-1:0];
        ready = 1'b1;
        @(negedge clock);
        ready = 1'b0;
        repeat (sample_period - 2) @(negedge clock);
        check_line(k);
      end

      $display("errors: %0d", error_count);
      if (error_count == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

  ////////////////////
  // watchdog
  ////////////////////

  initial begin
    longint limit_ns;
    wait (trace_loaded);
    limit_ns = longint'(trace_x.size()) * sample_period * 100 + 10000;
    #(limit_ns);
    $display("timeout, the run did not finish within %0d ns", limit_ns);
    $display("errors: %0d", error_count);
    $display("Checks failed");
    $finish;
  end

endmodule

//--- verif/audio_trace.txt
# columns: input sample x, expected y, expected beat, expected d (all decimal)
# impulse at sample 1, step of 64 on samples 33 to 60, then silence
127 -1 0 0
0 -1 0 0
0 -1 0 0
0 -1 0 0
0 0 0 0
0 0 0 0
0 0 0 0
0 1 0 0
0 2 0 0
0 4 1 1
0 5 0 2
0 7 0 2
0 8 0 6
0 10 0 12
0 11 0 22
0 11 0 38
0 11 0 62
0 11 0 94
0 10 0 134
0 8 0 180
0 7 0 232
0 5 0 288
0 4 0 348
0 2 0 408
0 1 0 470
0 0 0 532
0 0 0 594
0 0 0 652
0 -1 0 704
0 -1 0 750
0 -1 0 782
0 -1 0 796
64 -1 0 786
64 -1 0 754
64 -1 0 700
64 -1 0 624
64 -1 0 530
64 -1 0 422
64 0 0 306
64 1 0 186
64 2 0 62
64 4 0 0
64 7 0 0
64 11 0 0
64 15 0 0
64 20 0 0
64 26 0 0
64 32 0 0
64 37 0 0
64 43 0 0
64 48 0 0
64 52 0 168
64 56 0 704
64 59 0 1418
64 61 0 2338
64 62 0 3482
64 63 0 4860
64 64 0 6478
64 64 0 8344
64 64 0 10462
0 64 0 12824
0 64 0 15418
0 64 0 18222
0 64 0 21200
0 64 0 24300
0 64 0 27458
0 63 0 30606
0 62 0 33656
0 61 0 36518
0 59 0 39108
0 56 0 41340
0 52 0 43134
0 48 0 44428
0 43 0 45168
0 37 0 45310
0 32 0 44802
0 26 1 43621
0 20 0 41758

//--- sources.f
+incdir+src
src/beat_pkg.sv
src/fir_coeff_rom.sv
src/fir_filter.sv
src/energy_novelty.sv
src/peak_picker.sv
src/audio_processor.sv
verif/audio_processor_tb.sv

//--- Bender.yml
package:
  name: beat_detector

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/beat_pkg.sv
      - src/fir_coeff_rom.sv
      - src/fir_filter.sv
      - src/energy_novelty.sv
      - src/peak_picker.sv
      - src/audio_processor.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/audio_processor_tb.sv
